// File: verilog.f
+incdir+include
verilog/mac_pkg.sv
verilog/mac_regfile_3r1w.sv
verilog/mac_datapath.sv
verilog/mac_elem_counter.sv
verilog/mac_sequencer.sv
verilog/mac_axil_slave.sv
verilog/mac_top.sv
tests/mac_tb.sv

// File: Bender.yml
package:
  name: mac_engine

export_include_dirs:
  - include

sources:
  - verilog/mac_pkg.sv
  - verilog/mac_regfile_3r1w.sv
  - verilog/mac_datapath.sv
  - verilog/mac_elem_counter.sv
  - verilog/mac_sequencer.sv
  - verilog/mac_axil_slave.sv
  - verilog/mac_top.sv
  - target: test
    files:
      - tests/mac_tb.sv

// File: tests/mac_tb.sv
// random-stimulus testbench for the mac engine, AXI4-Lite driver plus a reference register model
`include "mac_cfg.svh"
`default_nettype none

module mac_tb
   import mac_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [3:0] addr_cmd    = 4'h0;
   localparam logic [3:0] addr_wdata  = 4'h4;
   localparam logic [3:0] addr_rdata  = 4'h8;
   localparam logic [3:0] addr_status = 4'hc;
   localparam int         timeout_cycles = 200;

   logic      clk_i;
   logic      rst_i;
   axil_req_t req;
   axil_rsp_t rsp;

   // reference model of the engine state
   logic [31:0] model_regs [`MAC_NUM_REGS];
   logic [31:0] model_wdata;
   logic [31:0] model_rdata;
   logic [7:0]  model_done;

   string test_name;
   int    test_errs;
   int    tests_passed;
   int    tests_failed;
   bit    hung;

   mac_top uut (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .s_axil_req_i (req),
      .s_axil_rsp_o (rsp)
   );

   initial clk_i = 1'b0;
   always #5 clk_i = ~clk_i;

   task automatic note_timeout(input string what);
      $display("ERROR in test %s: %s", test_name, what);
      test_errs++;
      hung = 1'b1;
   endtask

   task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("MISMATCH %s (%s): expected %h, actual %h", test_name, what, exp, act);
         test_errs++;
      end
   endtask

   // AW and W together, then wait for B; handshakes sampled at the falling edge
   task automatic write_bus(input logic [3:0] addr, input logic [31:0] data);
      int         cnt;
      bit         ok;
      logic       wr_rdy;
      logic [1:0] resp;
      if (hung)
      begin
         return;
      end
      @(posedge clk_i);
      #1;
      req.awvalid = 1'b1;
      req.awaddr  = addr;
      req.wvalid  = 1'b1;
      req.wdata   = data;
      req.wstrb   = '1;
      cnt    = 0;
      ok     = 1'b0;
      wr_rdy = 1'b0;
      while (!ok && cnt < timeout_cycles)
      begin
         @(negedge clk_i);
         ok     = rsp.awready;
         wr_rdy = rsp.wready;
         @(posedge clk_i);
         cnt++;
      end
      #1;
      req.awvalid = 1'b0;
      req.wvalid  = 1'b0;
      if (!ok)
      begin
         note_timeout("write address and data were never accepted");
         return;
      end
      // AW and W are taken in the same cycle
      check_word("wready with awready", 32'h1, {31'h0, wr_rdy});
      req.bready = 1'b1;
      cnt  = 0;
      ok   = 1'b0;
      resp = 2'b00;
      while (!ok && cnt < timeout_cycles)
      begin
         @(negedge clk_i);
         ok   = rsp.bvalid;
         resp = rsp.bresp;
         @(posedge clk_i);
         cnt++;
      end
      #1;
      req.bready = 1'b0;
      if (!ok)
      begin
         note_timeout("write response never arrived");
      end
      else
      begin
         check_word("bresp", 32'h0, {30'h0, resp});
      end
   endtask

   task automatic read_bus(input logic [3:0] addr, output logic [31:0] data);
      int         cnt;
      bit         ok;
      logic [1:0] resp;
      data = '0;
      if (hung)
      begin
         return;
      end
      @(posedge clk_i);
      #1;
      req.arvalid = 1'b1;
      req.araddr  = addr;
      cnt = 0;
      ok  = 1'b0;
      while (!ok && cnt < timeout_cycles)
      begin
         @(negedge clk_i);
         ok = rsp.arready;
         @(posedge clk_i);
         cnt++;
      end
      #1;
      req.arvalid = 1'b0;
      if (!ok)
      begin
         note_timeout("read address was never accepted");
         return;
      end
      req.rready = 1'b1;
      cnt  = 0;
      ok   = 1'b0;
      resp = 2'b00;
      while (!ok && cnt < timeout_cycles)
      begin
         @(negedge clk_i);
         ok   = rsp.rvalid;
         data = rsp.rdata;
         resp = rsp.rresp;
         @(posedge clk_i);
         cnt++;
      end
      #1;
      req.rready = 1'b0;
      if (!ok)
      begin
         note_timeout("read data never arrived");
      end
      else
      begin
         check_word("rresp", 32'h0, {30'h0, resp});
      end
   endtask

   // poll STATUS until busy clears
   task automatic wait_idle(output logic [31:0] status);
      int          cnt;
      logic [31:0] st;
      cnt = 0;
      st  = 32'h1;
      while (st[0] && cnt < timeout_cycles && !hung)
      begin
         read_bus(addr_status, st);
         cnt++;
      end
      if (st[0] && !hung)
      begin
         note_timeout("engine stayed busy");
      end
      status = st;
   endtask

   task automatic issue_cmd(input logic [31:0] cmd);
      logic [31:0] st;
      write_bus(addr_cmd, cmd);
      model_done++;
      wait_idle(st);
      check_word("status after command", {16'h0, model_done, 8'h00}, st);
   endtask

   task automatic load_reg(input int idx, input logic [31:0] val);
      cmd_word_u c;
      c = '0;
      c.access.op      = op_write_reg;
      c.access.reg_idx = 5'(idx);
      write_bus(addr_wdata, val);
      model_wdata = val;
      issue_cmd(c);
      model_regs[idx] = val;
   endtask

   task automatic fetch_reg(input int idx);
      cmd_word_u   c;
      logic [31:0] act;
      c = '0;
      c.access.op      = op_read_reg;
      c.access.reg_idx = 5'(idx);
      issue_cmd(c);
      model_rdata = model_regs[idx];
      read_bus(addr_rdata, act);
      check_word($sformatf("reg %0d", idx), model_rdata, act);
   endtask

   function automatic logic [31:0] exec_word(input bit sub, input int n, input logic [4:0] rd,
                                             input logic [4:0] rs0, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
      cmd_word_u c;
      c = '0;
      c.exec.op       = op_exec;
      c.exec.sub      = sub;
      c.exec.count_m1 = 5'(n - 1);
      c.exec.rd       = rd;
      c.exec.rs0      = rs0;
      c.exec.rs1      = rs1;
      c.exec.rs2      = rs2;
      return c;
   endfunction

   // rd+i = rs0+i * rs1+i +/- rs2+i, indices and values wrap
   function automatic void model_exec(input bit sub, input int n, input logic [4:0] rd,
                                      input logic [4:0] rs0, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
      logic [31:0] prod;
      for (int i = 0; i < n; i++)
      begin
         prod = model_regs[(rs0 + i) % 32] * model_regs[(rs1 + i) % 32];
         if (sub)
         begin
            model_regs[(rd + i) % 32] = prod - model_regs[(rs2 + i) % 32];
         end
         else
         begin
            model_regs[(rd + i) % 32] = prod + model_regs[(rs2 + i) % 32];
         end
      end
   endfunction

   // a source run starting n to 32-n past rd never touches the destination run
   function automatic logic [4:0] run_start(input logic [4:0] rd, input int n);
      int gap;
      gap = n + int'($urandom % (33 - 2 * n));
      return 5'((int'(rd) + gap) % 32);
   endfunction

   task automatic fetch_run(input logic [4:0] rd, input int n);
      for (int i = 0; i < n; i++)
      begin
         fetch_reg((rd + i) % 32);
      end
   endtask

   task automatic exec_series(input bit sub);
      int         n;
      logic [4:0] rd;
      logic [4:0] rs0;
      logic [4:0] rs1;
      logic [4:0] rs2;
      for (int k = 0; k < 6; k++)
      begin
         // first run always wraps past register 31
         n   = (k == 0) ? 12 : 1 + $urandom % 16;
         rd  = (k == 0) ? 5'd26 : 5'($urandom);
         rs0 = run_start(rd, n);
         rs1 = run_start(rd, n);
         rs2 = run_start(rd, n);
         issue_cmd(exec_word(sub, n, rd, rs0, rs1, rs2));
         model_exec(sub, n, rd, rs0, rs1, rs2);
         fetch_run(rd, n);
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic close_test();
      if (test_errs == 0)
      begin
         $display("test %s: ok", test_name);
         tests_passed++;
      end
      else
      begin
         $display("test %s: %0d errors", test_name, test_errs);
         tests_failed++;
      end
   endtask

   initial
   begin
      logic [31:0] v;
      logic [31:0] st;
      logic [31:0] st_bp;
      logic [7:0]  done_before;
      int          idx_list [12];
      logic [4:0]  rd_a;
      logic [4:0]  rd_b;
      logic [4:0]  src_a [3];
      logic [4:0]  src_b [3];
      int          n_b;

      void'($urandom(32'hd295_605b));
      req          = '0;
      rst_i        = 1'b1;
      hung         = 1'b0;
      tests_passed = 0;
      tests_failed = 0;
      model_wdata  = '0;
      model_rdata  = '0;
      model_done   = '0;
      for (int i = 0; i < `MAC_NUM_REGS; i++)
      begin
         model_regs[i] = '0;
      end
      repeat (10) @(posedge clk_i);
      #1;
      rst_i = 1'b0;

      start_test("reset");
      read_bus(addr_status, v);
      check_word("status", 32'h0, v);
      read_bus(addr_rdata, v);
      check_word("rdata", 32'h0, v);
      read_bus(addr_wdata, v);
      check_word("wdata", 32'h0, v);
      for (int i = 0; i < 4; i++)
      begin
         fetch_reg($urandom % 32);
      end
      close_test();

      start_test("register round trip");
      for (int i = 0; i < 12; i++)
      begin
         idx_list[i] = $urandom % 32;
         load_reg(idx_list[i], $urandom);
         read_bus(addr_wdata, v);
         check_word("wdata readback", model_wdata, v);
      end
      for (int i = 0; i < 12; i++)
      begin
         fetch_reg(idx_list[i]);
      end
      close_test();

      start_test("multiply-add");
      for (int i = 0; i < `MAC_NUM_REGS; i++)
      begin
         load_reg(i, $urandom);
      end
      exec_series(1'b0);
      close_test();

      start_test("multiply-subtract");
      exec_series(1'b1);
      close_test();

      start_test("back-pressure");
      rd_a = 5'($urandom);
      rd_b = 5'($urandom);
      n_b  = 1 + $urandom % 16;
      for (int k = 0; k < 3; k++)
      begin
         src_a[k] = run_start(rd_a, 16);
         src_b[k] = run_start(rd_b, n_b);
      end
      read_bus(addr_status, v);
      done_before = v[15:8];
      write_bus(addr_cmd, exec_word(1'b0, 16, rd_a, src_a[0], src_a[1], src_a[2]));
      fork
         begin
            write_bus(addr_cmd, exec_word(1'b1, n_b, rd_b, src_b[0], src_b[1], src_b[2]));
         end
         begin
            read_bus(addr_status, st_bp);
         end
      join
      // first command still running while the second write waits
      check_word("status while second command waits", {16'h0, done_before, 8'h01}, st_bp);
      // second response only once the first command has finished and the second started
      read_bus(addr_status, st);
      check_word("status after second response", {16'h0, done_before + 8'd1, 8'h01}, st);
      model_done = model_done + 8'd2;
      wait_idle(st);
      check_word("done count rise", {16'h0, done_before + 8'd2, 8'h00}, st);
      model_exec(1'b0, 16, rd_a, src_a[0], src_a[1], src_a[2]);
      model_exec(1'b1, n_b, rd_b, src_b[0], src_b[1], src_b[2]);
      fetch_run(rd_a, 16);
      fetch_run(rd_b, n_b);
      close_test();

      start_test("nop and ignored writes");
      issue_cmd(32'h0);
      write_bus(addr_rdata, $urandom);
      write_bus(addr_status, $urandom);
      read_bus(addr_rdata, v);
      check_word("rdata after write", model_rdata, v);
      read_bus(addr_status, v);
      check_word("status after write", {16'h0, model_done, 8'h00}, v);
      for (int i = 0; i < `MAC_NUM_REGS; i++)
      begin
         fetch_reg(i);
      end
      close_test();

      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0)
      begin
         $display("Result: PASSED");
      end
      else
      begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/mac_top.sv
// mac engine top level joining the AXI4-Lite slave, sequencer, counter, register file and datapath
`include "mac_cfg.svh"
`default_nettype none

module mac_top
   import mac_pkg::*;
(
   input  wire logic      clk_i,
   input  wire logic      rst_i,
   input  wire axil_req_t s_axil_req_i,
   output axil_rsp_t      s_axil_rsp_o
);

   logic                   cmd_valid;
   logic                   cmd_ready;
   cmd_word_u              cmd;
   logic [`MAC_DATA_W-1:0] wdata;
   logic                   rd_capture;
   logic [`MAC_DATA_W-1:0] rd_data;
   logic                   busy;
   logic [7:0]             done_count;

   logic                   w_v;
   logic [`MAC_IDX_W-1:0]  w_addr;
   logic [`MAC_DATA_W-1:0] w_data;
   logic [2:0]             r_v;
   logic [`MAC_IDX_W-1:0]  r0_addr;
   logic [`MAC_IDX_W-1:0]  r1_addr;
   logic [`MAC_IDX_W-1:0]  r2_addr;
   logic [`MAC_DATA_W-1:0] r0_data;
   logic [`MAC_DATA_W-1:0] r1_data;
   logic [`MAC_DATA_W-1:0] r2_data;

   logic                   cnt_load;
   logic [`MAC_IDX_W-1:0]  cnt_count_m1;
   logic [`MAC_IDX_W-1:0]  cnt_index;
   logic                   cnt_issue_last;
   logic                   cnt_drain_done;

   logic                   ops_valid;
   logic [`MAC_IDX_W:0]    ops_meta;
   operands_t              ops;
   result_t                res;

   mac_axil_slave u_slave (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .axil_req_i   (s_axil_req_i),
      .axil_rsp_o   (s_axil_rsp_o),
      .cmd_valid_o  (cmd_valid),
      .cmd_o        (cmd),
      .cmd_ready_i  (cmd_ready),
      .wdata_o      (wdata),
      .rd_capture_i (rd_capture),
      .rd_data_i    (rd_data),
      .busy_i       (busy),
      .done_count_i (done_count)
   );

   mac_sequencer u_seq (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .cmd_valid_i      (cmd_valid),
      .cmd_i            (cmd),
      .cmd_ready_o      (cmd_ready),
      .wdata_i          (wdata),
      .rd_capture_o     (rd_capture),
      .rd_data_o        (rd_data),
      .busy_o           (busy),
      .done_count_o     (done_count),
      .w_v_o            (w_v),
      .w_addr_o         (w_addr),
      .w_data_o         (w_data),
      .r_v_o            (r_v),
      .r0_addr_o        (r0_addr),
      .r1_addr_o        (r1_addr),
      .r2_addr_o        (r2_addr),
      .r0_data_i        (r0_data),
      .cnt_load_o       (cnt_load),
      .cnt_count_m1_o   (cnt_count_m1),
      .cnt_index_i      (cnt_index),
      .cnt_issue_last_i (cnt_issue_last),
      .cnt_drain_done_i (cnt_drain_done),
      .ops_valid_o      (ops_valid),
      .ops_meta_o       (ops_meta),
      .res_i            (res)
   );

   mac_elem_counter u_cnt (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .load_i       (cnt_load),
      .count_m1_i   (cnt_count_m1),
      .index_o      (cnt_index),
      .issue_last_o (cnt_issue_last),
      .drain_done_o (cnt_drain_done)
   );

   mac_regfile_3r1w #(
      .width_p (`MAC_DATA_W),
      .els_p   (`MAC_NUM_REGS)
   ) u_rf (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .w_v_i     (w_v),
      .w_addr_i  (w_addr),
      .w_data_i  (w_data),
      .r0_v_i    (r_v[0]),
      .r0_addr_i (r0_addr),
      .r0_data_o (r0_data),
      .r1_v_i    (r_v[1]),
      .r1_addr_i (r1_addr),
      .r1_data_o (r1_data),
      .r2_v_i    (r_v[2]),
      .r2_addr_i (r2_addr),
      .r2_data_o (r2_data)
   );

   // read data meets the sub flag and destination delayed by the sequencer
   assign ops = '{
      rs0_data: r0_data,
      rs1_data: r1_data,
      rs2_data: r2_data,
      sub:      ops_meta[`MAC_IDX_W],
      rd:       ops_meta[`MAC_IDX_W-1:0]
   };

   mac_datapath u_dp (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ops_valid_i (ops_valid),
      .ops_i       (ops),
      .res_o       (res)
   );

endmodule

`default_nettype wire

// File: verilog/mac_axil_slave.sv
// AXI4-Lite register window holding WDATA and RDATA, handing off commands and reporting status
`include "mac_cfg.svh"
`default_nettype none

module mac_axil_slave
   import mac_pkg::*;
(
   input  wire logic                   clk_i,
   input  wire logic                   rst_i,
   input  wire axil_req_t              axil_req_i,
   output axil_rsp_t                   axil_rsp_o,

   output logic                        cmd_valid_o,
   output cmd_word_u                   cmd_o,
   input  wire logic                   cmd_ready_i,
   output logic      [`MAC_DATA_W-1:0] wdata_o,

   input  wire logic                   rd_capture_i,
   input  wire logic [`MAC_DATA_W-1:0] rd_data_i,
   input  wire logic                   busy_i,
   input  wire logic [7:0]             done_count_i
);

   localparam logic [1:0] reg_cmd    = 2'd0;
   localparam logic [1:0] reg_wdata  = 2'd1;
   localparam logic [1:0] reg_rdata  = 2'd2;
   localparam logic [1:0] reg_status = 2'd3;

   logic                   wr_accept;
   logic                   rd_accept;
   logic [1:0]             wr_sel;
   logic [1:0]             rd_sel;
   logic                   bvalid_q;
   logic                   rvalid_q;
   logic                   cmd_valid_q;
   cmd_word_u              cmd_q;
   logic [`MAC_DATA_W-1:0] wdata_q;
   logic [`MAC_DATA_W-1:0] rdata_reg_q;
   logic [`MAC_DATA_W-1:0] rdata_q;
   logic [`MAC_DATA_W-1:0] rd_mux;

   // AW and W go together, and a pending command also blocks the next write
   assign wr_accept = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q & ~cmd_valid_q;
   assign rd_accept = axil_req_i.arvalid & ~rvalid_q;
   assign wr_sel = axil_req_i.awaddr[`MAC_AXIL_ADDR_W-1:2];
   assign rd_sel = axil_req_i.araddr[`MAC_AXIL_ADDR_W-1:2];

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         bvalid_q    <= 1'b0;
         cmd_valid_q <= 1'b0;
         wdata_q     <= '0;
         rdata_reg_q <= '0;
      end
      else
      begin
         if (wr_accept)
         begin
            // B for a command is held back until the sequencer takes it
            if (wr_sel == reg_cmd)
            begin
               cmd_valid_q <= 1'b1;
            end
            else
            begin
               bvalid_q <= 1'b1;
            end
            if (wr_sel == reg_wdata)
            begin
               wdata_q <= axil_req_i.wdata;
            end
         end
         if (cmd_valid_q & cmd_ready_i)
         begin
            cmd_valid_q <= 1'b0;
            bvalid_q    <= 1'b1;
         end
         if (bvalid_q & axil_req_i.bready)
         begin
            bvalid_q <= 1'b0;
         end
         if (rd_capture_i)
         begin
            rdata_reg_q <= rd_data_i;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (wr_accept & (wr_sel == reg_cmd))
      begin
         cmd_q <= axil_req_i.wdata;
      end
   end

   always_comb
   begin
      rd_mux = '0;
      unique case (rd_sel)
         reg_wdata:  rd_mux = wdata_q;
         reg_rdata:  rd_mux = rdata_reg_q;
         reg_status:
         begin
            rd_mux[0]    = busy_i;
            rd_mux[15:8] = done_count_i;
         end
         // CMD is write-only and reads as zero
         default:    rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         rvalid_q <= 1'b0;
      end
      else if (rd_accept)
      begin
         rvalid_q <= 1'b1;
      end
      else if (axil_req_i.rready)
      begin
         rvalid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rd_accept)
      begin
         rdata_q <= rd_mux;
      end
   end

   // responses are always OKAY
   assign axil_rsp_o = '{
      awready: wr_accept,
      wready:  wr_accept,
      bvalid:  bvalid_q,
      bresp:   2'b00,
      arready: ~rvalid_q,
      rvalid:  rvalid_q,
      rdata:   rdata_q,
      rresp:   2'b00
   };

   assign cmd_valid_o = cmd_valid_q;
   assign cmd_o       = cmd_q;
   assign wdata_o     = wdata_q;

endmodule

`default_nettype wire

// File: verilog/mac_sequencer.sv
// command FSM that drives the register file ports, issues EXEC elements and counts completions
`include "mac_cfg.svh"
`default_nettype none

module mac_sequencer
   import mac_pkg::*;
(
   input  wire logic                   clk_i,
   input  wire logic                   rst_i,

   input  wire logic                   cmd_valid_i,
   input  wire cmd_word_u              cmd_i,
   output logic                        cmd_ready_o,
   input  wire logic [`MAC_DATA_W-1:0] wdata_i,

   output logic                        rd_capture_o,
   output logic      [`MAC_DATA_W-1:0] rd_data_o,
   output logic                        busy_o,
   output logic      [7:0]             done_count_o,

   output logic                        w_v_o,
   output logic      [`MAC_IDX_W-1:0]  w_addr_o,
   output logic      [`MAC_DATA_W-1:0] w_data_o,
   output logic      [2:0]             r_v_o,
   output logic      [`MAC_IDX_W-1:0]  r0_addr_o,
   output logic      [`MAC_IDX_W-1:0]  r1_addr_o,
   output logic      [`MAC_IDX_W-1:0]  r2_addr_o,
   input  wire logic [`MAC_DATA_W-1:0] r0_data_i,

   output logic                        cnt_load_o,
   output logic      [`MAC_IDX_W-1:0]  cnt_count_m1_o,
   input  wire logic [`MAC_IDX_W-1:0]  cnt_index_i,
   input  wire logic                   cnt_issue_last_i,
   input  wire logic                   cnt_drain_done_i,

   output logic                        ops_valid_o,
   output logic      [`MAC_IDX_W:0]    ops_meta_o,
   input  wire result_t                res_i
);

   typedef enum logic [2:0] {
      s_idle,
      s_write,
      s_read,
      s_capture,
      s_issue,
      s_drain
   } state_e;

   state_e                state_q;
   state_e                state_n;
   cmd_word_u             cmd_q;
   logic                  accept;
   logic                  finish;
   logic [7:0]            done_count_q;
   logic                  ops_valid_q;
   logic [`MAC_IDX_W:0]   meta_q;
   logic [`MAC_IDX_W-1:0] dest_idx;

   assign cmd_ready_o = (state_q == s_idle);
   assign accept = cmd_valid_i & cmd_ready_o;

   always_comb
   begin
      state_n = state_q;
      finish  = 1'b0;
      unique case (state_q)
         s_idle:
         begin
            if (cmd_valid_i)
            begin
               unique case (cmd_i.access.op)
                  op_read_reg: state_n = s_read;
                  op_exec:     state_n = s_issue;
                  // nop also spends its one busy cycle here
                  default:     state_n = s_write;
               endcase
            end
         end
         s_write:
         begin
            state_n = s_idle;
            finish  = 1'b1;
         end
         s_read:    state_n = s_capture;
         s_capture:
         begin
            state_n = s_idle;
            finish  = 1'b1;
         end
         s_issue:
         begin
            if (cnt_issue_last_i)
            begin
               state_n = s_drain;
            end
         end
         default:
         begin
            if (cnt_drain_done_i)
            begin
               state_n = s_idle;
               finish  = 1'b1;
            end
         end
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q      <= s_idle;
         done_count_q <= '0;
         ops_valid_q  <= 1'b0;
      end
      else
      begin
         state_q      <= state_n;
         done_count_q <= done_count_q + {7'd0, finish};
         ops_valid_q  <= (state_q == s_issue);
      end
   end

   // sub and destination line up with the synchronous read data
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         cmd_q <= cmd_i;
      end
      meta_q <= {cmd_q.exec.sub, dest_idx};
   end

   // 5-bit sums wrap the runs past register 31
   assign dest_idx  = cmd_q.exec.rd + cnt_index_i;
   assign r0_addr_o = (state_q == s_read) ? cmd_q.access.reg_idx : cmd_q.exec.rs0 + cnt_index_i;
   assign r1_addr_o = cmd_q.exec.rs1 + cnt_index_i;
   assign r2_addr_o = cmd_q.exec.rs2 + cnt_index_i;

   always_comb
   begin
      unique case (state_q)
         s_read:  r_v_o = 3'b001;
         s_issue: r_v_o = 3'b111;
         default: r_v_o = 3'b000;
      endcase
   end

   // WRITE_REG only runs out of idle, so it never meets a datapath result
   always_comb
   begin
      if (state_q == s_write)
      begin
         w_v_o    = (cmd_q.access.op == op_write_reg);
         w_addr_o = cmd_q.access.reg_idx;
         w_data_o = wdata_i;
      end
      else
      begin
         w_v_o    = res_i.v;
         w_addr_o = res_i.idx;
         w_data_o = res_i.data;
      end
   end

   assign cnt_load_o     = accept & (cmd_i.exec.op == op_exec);
   assign cnt_count_m1_o = cmd_i.exec.count_m1;

   assign rd_capture_o = (state_q == s_capture);
   assign rd_data_o    = r0_data_i;
   assign busy_o       = (state_q != s_idle);
   assign done_count_o = done_count_q;
   assign ops_valid_o  = ops_valid_q;
   assign ops_meta_o   = meta_q;

endmodule

`default_nettype wire

// File: verilog/mac_elem_counter.sv
// element index for EXEC issue plus the two-cycle drain that covers write-back
`include "mac_cfg.svh"
`default_nettype none

module mac_elem_counter (
   input  wire logic                  clk_i,
   input  wire logic                  rst_i,
   input  wire logic                  load_i,
   input  wire logic [`MAC_IDX_W-1:0] count_m1_i,
   output logic      [`MAC_IDX_W-1:0] index_o,
   output logic                       issue_last_o,
   output logic                       drain_done_o
);

   logic [`MAC_IDX_W-1:0] index_q;
   logic [`MAC_IDX_W-1:0] last_q;
   logic                  issuing_q;
   logic                  draining_q;
   logic                  drain_cnt_q;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         index_q     <= '0;
         issuing_q   <= 1'b0;
         draining_q  <= 1'b0;
         drain_cnt_q <= 1'b0;
      end
      else if (load_i)
      begin
         index_q     <= '0;
         issuing_q   <= 1'b1;
         draining_q  <= 1'b0;
         drain_cnt_q <= 1'b0;
      end
      else if (issuing_q)
      begin
         if (index_q == last_q)
         begin
            issuing_q  <= 1'b0;
            draining_q <= 1'b1;
         end
         else
         begin
            index_q <= index_q + 1'b1;
         end
      end
      else if (draining_q)
      begin
         // datapath register, then register file write
         drain_cnt_q <= 1'b1;
         if (drain_cnt_q)
         begin
            draining_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (load_i)
      begin
         last_q <= count_m1_i;
      end
   end

   assign index_o      = index_q;
   assign issue_last_o = issuing_q & (index_q == last_q);
   assign drain_done_o = draining_q & drain_cnt_q;

endmodule

`default_nettype wire

// File: verilog/mac_datapath.sv
// one registered multiply then add or subtract stage, one element per cycle
`include "mac_cfg.svh"
`default_nettype none

module mac_datapath
   import mac_pkg::*;
(
   input  wire logic      clk_i,
   input  wire logic      rst_i,
   input  wire logic      ops_valid_i,
   input  wire operands_t ops_i,
   output result_t        res_o
);

   logic [`MAC_DATA_W-1:0] product;
   logic [`MAC_DATA_W-1:0] sum;
   logic                   res_v_q;
   logic [`MAC_IDX_W-1:0]  res_idx_q;
   logic [`MAC_DATA_W-1:0] res_data_q;

   // low half of the product only, arithmetic is modulo 2^32
   assign product = ops_i.rs0_data * ops_i.rs1_data;
   assign sum = ops_i.sub ? (product - ops_i.rs2_data) : (product + ops_i.rs2_data);

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         res_v_q <= 1'b0;
      end
      else
      begin
         res_v_q <= ops_valid_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (ops_valid_i)
      begin
         res_idx_q  <= ops_i.rd;
         res_data_q <= sum;
      end
   end

   assign res_o = '{v: res_v_q, idx: res_idx_q, data: res_data_q};

endmodule

`default_nettype wire

// File: verilog/mac_regfile_3r1w.sv
// register array with one write port and three synchronous read ports
`default_nettype none

module mac_regfile_3r1w #(
   parameter int width_p = 32,
   parameter int els_p = 32,
   localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
   input  wire logic                     clk_i,
   input  wire logic                     rst_i,

   input  wire logic                     w_v_i,
   input  wire logic [addr_width_lp-1:0] w_addr_i,
   input  wire logic [width_p-1:0]       w_data_i,

   input  wire logic                     r0_v_i,
   input  wire logic [addr_width_lp-1:0] r0_addr_i,
   output logic      [width_p-1:0]       r0_data_o,

   input  wire logic                     r1_v_i,
   input  wire logic [addr_width_lp-1:0] r1_addr_i,
   output logic      [width_p-1:0]       r1_data_o,

   input  wire logic                     r2_v_i,
   input  wire logic [addr_width_lp-1:0] r2_addr_i,
   output logic      [width_p-1:0]       r2_data_o
);

   logic [width_p-1:0]       mem_q [els_p];
   logic [2:0]               r_v;
   logic [addr_width_lp-1:0] r_addr [3];
   logic [width_p-1:0]       r_data_q [3];

   assign r_v = {r2_v_i, r1_v_i, r0_v_i};
   assign r_addr[0] = r0_addr_i;
   assign r_addr[1] = r1_addr_i;
   assign r_addr[2] = r2_addr_i;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         for (int i = 0; i < els_p; i++)
         begin
            mem_q[i] <= '0;
         end
      end
      else if (w_v_i)
      begin
         mem_q[w_addr_i] <= w_data_i;
      end
   end

   // a read racing a write to the same entry sees the old word
   always_ff @(posedge clk_i)
   begin
      for (int k = 0; k < 3; k++)
      begin
         if (r_v[k])
         begin
            r_data_q[k] <= mem_q[r_addr[k]];
         end
      end
   end

   assign r0_data_o = r_data_q[0];
   assign r1_data_o = r_data_q[1];
   assign r2_data_o = r_data_q[2];

endmodule

`default_nettype wire

// File: verilog/mac_pkg.sv
// types shared by the mac engine: command views, AXI4-Lite bundles and datapath records
`include "mac_cfg.svh"
`default_nettype none

package mac_pkg;

   typedef enum logic [1:0] {
      op_nop       = 2'd0,
      op_write_reg = 2'd1,
      op_read_reg  = 2'd2,
      op_exec      = 2'd3
   } cmd_op_e;

   // opcode sits in the two low bits of both views
   typedef struct packed {
      logic [3:0]            rsvd;
      logic [`MAC_IDX_W-1:0] rs2;
      logic [`MAC_IDX_W-1:0] rs1;
      logic [`MAC_IDX_W-1:0] rs0;
      logic [`MAC_IDX_W-1:0] rd;
      logic [`MAC_IDX_W-1:0] count_m1;
      logic                  sub;
      cmd_op_e               op;
   } exec_cmd_t;

   typedef struct packed {
      logic [24:0]           rsvd;
      logic [`MAC_IDX_W-1:0] reg_idx;
      cmd_op_e               op;
   } access_cmd_t;

   typedef union packed {
      exec_cmd_t   exec;
      access_cmd_t access;
   } cmd_word_u;

   typedef struct packed {
      logic                        awvalid;
      logic [`MAC_AXIL_ADDR_W-1:0] awaddr;
      logic                        wvalid;
      logic [`MAC_DATA_W-1:0]      wdata;
      logic [`MAC_DATA_W/8-1:0]    wstrb;
      logic                        bready;
      logic                        arvalid;
      logic [`MAC_AXIL_ADDR_W-1:0] araddr;
      logic                        rready;
   } axil_req_t;

   typedef struct packed {
      logic                   awready;
      logic                   wready;
      logic                   bvalid;
      logic [1:0]             bresp;
      logic                   arready;
      logic                   rvalid;
      logic [`MAC_DATA_W-1:0] rdata;
      logic [1:0]             rresp;
   } axil_rsp_t;

   // one element on its way into the datapath
   typedef struct packed {
      logic [`MAC_DATA_W-1:0] rs0_data;
      logic [`MAC_DATA_W-1:0] rs1_data;
      logic [`MAC_DATA_W-1:0] rs2_data;
      logic                   sub;
      logic [`MAC_IDX_W-1:0]  rd;
   } operands_t;

   typedef struct packed {
      logic                   v;
      logic [`MAC_IDX_W-1:0]  idx;
      logic [`MAC_DATA_W-1:0] data;
   } result_t;

endpackage

`default_nettype wire

// File: include/mac_cfg.svh
// sizes of the mac engine register file and its AXI4-Lite register window
`ifndef MAC_CFG_SVH
`define MAC_CFG_SVH

// register width, also the AXI data bus width
`define MAC_DATA_W 32

// register file depth and the index width that addresses it
`define MAC_NUM_REGS 32
`define MAC_IDX_W 5

// four word registers: CMD 0x0, WDATA 0x4, RDATA 0x8, STATUS 0xC
`define MAC_AXIL_ADDR_W 4

`endif
